// ==== Makefile ====
# Verilator build and run for the saturn decoder testbench

VERILATOR ?= verilator
TOP       ?= tb_saturn_decoder
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILE_LIST)) $(wildcard *.svh)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

# status comes from the search for the pass line
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf $(BUILD_DIR)

// ==== dec_pkg.sv ====
/*
 * saturn decoder shared definitions
 * widths, instruction classes, alu operation codes and the
 * header and record structs passed between the decoder stages
 */
`default_nettype none

package dec_pkg;

  // datapath widths
  localparam int NIBBLE_W     = 4;
  localparam int ADDR_W       = 20;
  localparam int LOAD_NIBBLES = 16;
  localparam int LOAD_W       = LOAD_NIBBLES * NIBBLE_W;
  localparam int LEN_W        = 5;

  // instruction class found by the dispatcher
  typedef enum logic [2:0] {
    KIND_GRP0     = 3'd0,
    KIND_LOAD_P   = 3'd1,
    KIND_LOAD_C   = 3'd2,
    KIND_JMP_COND = 3'd3,
    KIND_JMP_ABS  = 3'd4,
    KIND_BAD      = 3'd5
  } op_kind_t;

  // alu operation carried in the record
  typedef enum logic [4:0] {
    ALU_OP_NOP      = 5'd0,
    ALU_OP_COPY     = 5'd1,
    ALU_OP_ZERO     = 5'd2,
    ALU_OP_EXCH     = 5'd3,
    ALU_OP_INC      = 5'd4,
    ALU_OP_DEC      = 5'd5,
    ALU_OP_JMP_REL2 = 5'd6,
    ALU_OP_JMP_REL3 = 5'd7
  } alu_op_t;

  // classified opcode, dispatcher to emitter
  typedef struct packed {
    logic                valid;
    op_kind_t            kind;
    logic [ADDR_W-1:0]   ins_addr;
    logic [NIBBLE_W-1:0] nib0;
    logic [NIBBLE_W-1:0] nib1;
  } dec_head_t;

  // decoded instruction record
  typedef struct packed {
    logic [ADDR_W-1:0]   ins_addr;
    alu_op_t             alu_op;
    logic [NIBBLE_W-1:0] imm_value;
    logic [LOAD_W-1:0]   load_value;
    logic [LEN_W-1:0]    load_len;
    // return and carry handling
    logic                rtn;
    logic                set_xm;
    logic                set_carry;
    logic                carry_val;
    logic                test_carry;
    logic                en_intr;
    // return stack
    logic                push;
    logic                pop;
    // hex / decimal mode
    logic                set_mode;
    logic                mode_dec;
  } dec_ins_t;

endpackage

`default_nettype wire

// ==== files.f ====
+incdir+.
dec_pkg.sv
sat_dec_dispatch.sv
sat_dec_operand.sv
sat_dec_emit.sv
saturn_decoder.sv
tb_saturn_decoder.sv

// ==== sat_dec_dispatch.sv ====
/*
 * opcode dispatcher
 * reads the first one or two nibbles of each instruction, classifies it
 * and asks the operand collector for any nibbles that follow
 */
`timescale 1ns/1ps
`default_nettype none

module sat_dec_dispatch
  import dec_pkg::*;
(
  input  wire                 i_clk,
  input  wire                 i_reset,
  input  wire                 i_accept,
  input  wire                 i_busy,
  input  wire  [NIBBLE_W-1:0] i_nibble,
  input  wire  [ADDR_W-1:0]   i_pc,
  output dec_head_t           o_head,
  output logic                o_opnd_req,
  output logic [LEN_W-1:0]    o_opnd_len
);

  typedef enum logic {
    ST_FIRST,
    ST_SECOND
  } state_t;

  state_t              state;
  state_t              state_d;
  dec_head_t           head_d;
  logic                req_d;
  logic [LEN_W-1:0]    len_d;
  logic                take;

  // first nibble held while the second one is awaited
  logic [ADDR_W-1:0]   addr_q;
  logic [NIBBLE_W-1:0] nib0_q;

  // operand nibbles belong to the collector
  assign take = i_accept && !i_busy;

  always_comb begin
    state_d = state;
    head_d  = '0;
    req_d   = 1'b0;
    len_d   = '0;
    if (take) begin
      if (state == ST_FIRST) begin
        head_d.ins_addr = i_pc;
        head_d.nib0     = i_nibble;
        case (i_nibble)
          4'h0, 4'h2, 4'h3: begin
            state_d = ST_SECOND;
          end
          4'h4, 4'h5: begin
            // GOC / GONC, two offset nibbles
            head_d.valid = 1'b1;
            head_d.kind  = KIND_JMP_COND;
            req_d        = 1'b1;
            len_d        = LEN_W'(2);
          end
          4'h6, 4'h7: begin
            // GOTO / GOSUB, three offset nibbles
            head_d.valid = 1'b1;
            head_d.kind  = KIND_JMP_ABS;
            req_d        = 1'b1;
            len_d        = LEN_W'(3);
          end
          default: begin
            head_d.valid = 1'b1;
            head_d.kind  = KIND_BAD;
          end
        endcase
      end else begin
        state_d         = ST_FIRST;
        head_d.valid    = 1'b1;
        head_d.ins_addr = addr_q;
        head_d.nib0     = nib0_q;
        head_d.nib1     = i_nibble;
        case (nib0_q)
          4'h0: begin
            // 0E opens the fields group, not kept
            head_d.kind = (i_nibble == 4'hE) ? KIND_BAD : KIND_GRP0;
          end
          4'h2: begin
            head_d.kind = KIND_LOAD_P;
          end
          default: begin
            // LC n loads n+1 nibbles
            head_d.kind = KIND_LOAD_C;
            req_d       = 1'b1;
            len_d       = LEN_W'(i_nibble) + 1'b1;
          end
        endcase
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state        <= ST_FIRST;
      o_head.valid <= 1'b0;
      o_opnd_req   <= 1'b0;
    end else begin
      state      <= state_d;
      o_head     <= head_d;
      o_opnd_req <= req_d;
    end
  end

  always_ff @(posedge i_clk) begin
    o_opnd_len <= len_d;
    if (take && state == ST_FIRST) begin
      addr_q <= i_pc;
      nib0_q <= i_nibble;
    end
  end

endmodule

`default_nettype wire

// ==== sat_dec_emit.sv ====
/*
 * record emitter
 * turns a classified header, plus its operands when it has any,
 * into the decoded record and the decoded or error pulse
 */
`timescale 1ns/1ps
`default_nettype none

module sat_dec_emit
  import dec_pkg::*;
(
  input  wire                i_clk,
  input  wire                i_reset,
  input  dec_head_t          i_head,
  input  wire                i_opnd_done,
  input  wire  [LOAD_W-1:0]  i_opnd_value,
  input  wire  [LEN_W-1:0]   i_opnd_len,
  output dec_ins_t           o_ins,
  output logic               o_ins_decoded,
  output logic               o_dec_error
);

  dec_head_t pend_head;
  dec_head_t fire_head;
  logic      pend_valid;
  logic      wait_opnd;
  logic      fire;

  function automatic logic has_operands(op_kind_t kind);
    return (kind == KIND_LOAD_C) || (kind == KIND_JMP_COND) || (kind == KIND_JMP_ABS);
  endfunction

  function automatic dec_ins_t build_ins(dec_head_t hd, logic [LOAD_W-1:0] value,
                                         logic [LEN_W-1:0] len);
    dec_ins_t r;
    r          = '0;
    r.ins_addr = hd.ins_addr;
    r.alu_op   = ALU_OP_NOP;
    case (hd.kind)
      KIND_GRP0: begin
        case (hd.nib1)
          4'h0, 4'h1, 4'h2, 4'h3, 4'hF: begin
            // returns, 0F also re-enables interrupts
            r.rtn       = 1'b1;
            r.pop       = 1'b1;
            r.set_xm    = (hd.nib1 == 4'h0);
            r.set_carry = !hd.nib1[3] && hd.nib1[1];
            r.carry_val = !hd.nib1[3] && hd.nib1[1] && hd.nib1[0];
            r.en_intr   = hd.nib1[3];
          end
          4'h4, 4'h5: begin
            r.set_mode = 1'b1;
            r.mode_dec = hd.nib1[0];
          end
          4'h6, 4'h7: begin
            // RSTK=C pushes, C=RSTK pops
            r.alu_op = ALU_OP_COPY;
            r.push   = !hd.nib1[0];
            r.pop    = hd.nib1[0];
          end
          4'h8:       r.alu_op = ALU_OP_ZERO;
          4'h9, 4'hA: r.alu_op = ALU_OP_COPY;
          4'hB:       r.alu_op = ALU_OP_EXCH;
          4'hC:       r.alu_op = ALU_OP_INC;
          4'hD:       r.alu_op = ALU_OP_DEC;
          default:    r.alu_op = ALU_OP_NOP;
        endcase
      end
      KIND_LOAD_P: begin
        r.alu_op    = ALU_OP_COPY;
        r.imm_value = hd.nib1;
      end
      KIND_LOAD_C: begin
        r.alu_op     = ALU_OP_COPY;
        r.load_value = value;
        r.load_len   = len;
      end
      KIND_JMP_COND: begin
        // 4xy jumps on carry set, 5xy on carry clear
        r.alu_op     = ALU_OP_JMP_REL2;
        r.test_carry = 1'b1;
        r.carry_val  = !hd.nib0[0];
        r.load_value = value;
        r.load_len   = len;
      end
      KIND_JMP_ABS: begin
        r.alu_op     = ALU_OP_JMP_REL3;
        r.push       = hd.nib0[0];
        r.load_value = value;
        r.load_len   = len;
      end
      default: r.alu_op = ALU_OP_NOP;
    endcase
    return r;
  endfunction

  assign wait_opnd = i_head.valid && has_operands(i_head.kind);
  assign fire      = (i_head.valid && !wait_opnd) || (i_opnd_done && pend_valid);
  assign fire_head = i_opnd_done ? pend_head : i_head;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      pend_valid    <= 1'b0;
      o_ins         <= '0;
      o_ins_decoded <= 1'b0;
      o_dec_error   <= 1'b0;
    end else begin
      if (wait_opnd) begin
        pend_valid <= 1'b1;
      end else if (i_opnd_done) begin
        pend_valid <= 1'b0;
      end
      o_ins_decoded <= fire && (fire_head.kind != KIND_BAD);
      o_dec_error   <= fire && (fire_head.kind == KIND_BAD);
      if (fire && fire_head.kind != KIND_BAD) begin
        o_ins <= build_ins(fire_head, i_opnd_value, i_opnd_len);
      end
    end
  end

  // header parked until the collector is done
  always_ff @(posedge i_clk) begin
    if (wait_opnd) begin
      pend_head <= i_head;
    end
  end

endmodule

`default_nettype wire

// ==== sat_dec_operand.sv ====
/*
 * operand collector
 * gathers the nibbles that follow an opcode into one value,
 * lowest nibble first, and pulses done when the last one is in
 */
`timescale 1ns/1ps
`default_nettype none

module sat_dec_operand
  import dec_pkg::*;
(
  input  wire                 i_clk,
  input  wire                 i_reset,
  input  wire                 i_accept,
  input  wire                 i_opnd_req,
  input  wire  [LEN_W-1:0]    i_opnd_len,
  input  wire  [NIBBLE_W-1:0] i_nibble,
  output logic                o_busy,
  output logic                o_opnd_done,
  output logic [LOAD_W-1:0]   o_opnd_value,
  output logic [LEN_W-1:0]    o_opnd_len
);

  logic [LEN_W-1:0]  pos;
  logic [LEN_W-1:0]  remain;
  logic [LEN_W-1:0]  cur_pos;
  logic [LEN_W-1:0]  cur_rem;
  logic [LOAD_W-1:0] value_d;
  logic              take;

  // a fresh request restarts at slot 0 in the same cycle
  assign cur_pos = i_opnd_req ? '0 : pos;
  assign cur_rem = i_opnd_req ? i_opnd_len : remain;
  assign take    = i_accept && (cur_rem != '0);
  assign o_busy  = i_opnd_req || (remain != '0);

  always_comb begin
    value_d = i_opnd_req ? '0 : o_opnd_value;
    if (take) begin
      value_d[cur_pos*NIBBLE_W +: NIBBLE_W] = i_nibble;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      pos         <= '0;
      remain      <= '0;
      o_opnd_done <= 1'b0;
    end else begin
      o_opnd_done <= take && (cur_rem == LEN_W'(1));
      if (take) begin
        pos    <= cur_pos + 1'b1;
        remain <= cur_rem - 1'b1;
      end else if (i_opnd_req) begin
        pos    <= '0;
        remain <= i_opnd_len;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    o_opnd_value <= value_d;
    if (i_opnd_req) begin
      o_opnd_len <= i_opnd_len;
    end
  end

endmodule

`default_nettype wire

// ==== saturn_decoder.sv ====
/*
 * saturn nibble-serial instruction decoder
 * dispatcher, operand collector and record emitter in a row,
 * one nibble consumed per accepted cycle
 */
`timescale 1ns/1ps
`default_nettype none

module saturn_decoder
  import dec_pkg::*;
(
  input  wire                 i_clk,
  input  wire                 i_reset,
  input  wire                 i_en_dec,
  input  wire                 i_stalled,
  input  wire  [ADDR_W-1:0]   i_pc,
  input  wire  [NIBBLE_W-1:0] i_nibble,
  output dec_ins_t            o_ins,
  output logic                o_ins_decoded,
  output logic                o_dec_error
);

  logic              accept;
  logic              busy;
  logic              opnd_req;
  logic [LEN_W-1:0]  req_len;
  dec_head_t         head;
  logic              opnd_done;
  logic [LOAD_W-1:0] opnd_value;
  logic [LEN_W-1:0]  opnd_len;

  // a nibble is taken whenever decoding is on and not held back
  assign accept = i_en_dec && !i_stalled;

  sat_dec_dispatch u_dispatch (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_accept   (accept),
    .i_busy     (busy),
    .i_nibble   (i_nibble),
    .i_pc       (i_pc),
    .o_head     (head),
    .o_opnd_req (opnd_req),
    .o_opnd_len (req_len)
  );

  sat_dec_operand u_operand (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_accept     (accept),
    .i_opnd_req   (opnd_req),
    .i_opnd_len   (req_len),
    .i_nibble     (i_nibble),
    .o_busy       (busy),
    .o_opnd_done  (opnd_done),
    .o_opnd_value (opnd_value),
    .o_opnd_len   (opnd_len)
  );

  sat_dec_emit u_emit (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_head        (head),
    .i_opnd_done   (opnd_done),
    .i_opnd_value  (opnd_value),
    .i_opnd_len    (opnd_len),
    .o_ins         (o_ins),
    .o_ins_decoded (o_ins_decoded),
    .o_dec_error   (o_dec_error)
  );

endmodule

`default_nettype wire

// ==== tb_decoder_model.svh ====
/*
 * decoder reference model for the testbench
 * builds random instructions as nibble streams and queues the
 * record or error pulse that each one must produce
 */

// instruction mix for one test
localparam int MODE_GRP0  = 0;
localparam int MODE_LOADP = 1;
localparam int MODE_LOADC = 2;
localparam int MODE_JUMP  = 3;
localparam int MODE_ERRS  = 4;
localparam int MODE_ANY   = 5;

task automatic add_nibble(input logic [NIBBLE_W-1:0] nib, input bit last);
  stim_nib.push_back(nib);
  stim_last.push_back(last);
  gen_addr = gen_addr + 1'b1;
endtask

// all flags low, alu idle
function automatic dec_ins_t empty_record(input logic [ADDR_W-1:0] addr);
  dec_ins_t r;
  r          = '0;
  r.ins_addr = addr;
  r.alu_op   = ALU_OP_NOP;
  return r;
endfunction

task automatic expect_record(input dec_ins_t r, input bit is_error);
  exp_ins.push_back(r);
  exp_err.push_back(is_error);
endtask

task automatic gen_group0();
  dec_ins_t            r;
  logic [NIBBLE_W-1:0] n;
  r = empty_record(gen_addr);
  n = NIBBLE_W'(rand_below(15));
  // 0E opens the fields group, which is not decoded
  if (n == 4'hE) begin
    n = 4'hF;
  end
  case (n)
    4'h0, 4'h1, 4'h2, 4'h3, 4'hF: begin
      // return family
      r.rtn       = 1'b1;
      r.pop       = 1'b1;
      r.set_xm    = (n == 4'h0);
      r.set_carry = (n == 4'h2) || (n == 4'h3);
      r.carry_val = (n == 4'h3);
      r.en_intr   = (n == 4'hF);
    end
    4'h4, 4'h5: begin
      r.set_mode = 1'b1;
      r.mode_dec = (n == 4'h5);
    end
    4'h6: begin
      r.alu_op = ALU_OP_COPY;
      r.push   = 1'b1;
    end
    4'h7: begin
      r.alu_op = ALU_OP_COPY;
      r.pop    = 1'b1;
    end
    4'h8: r.alu_op = ALU_OP_ZERO;
    4'h9, 4'hA: r.alu_op = ALU_OP_COPY;
    4'hB: r.alu_op = ALU_OP_EXCH;
    4'hC: r.alu_op = ALU_OP_INC;
    default: r.alu_op = ALU_OP_DEC;
  endcase
  add_nibble(4'h0, 1'b0);
  add_nibble(n, 1'b1);
  expect_record(r, 1'b0);
endtask

task automatic gen_load_p();
  dec_ins_t            r;
  logic [NIBBLE_W-1:0] n;
  r           = empty_record(gen_addr);
  n           = NIBBLE_W'(rand_below(16));
  r.alu_op    = ALU_OP_COPY;
  r.imm_value = n;
  add_nibble(4'h2, 1'b0);
  add_nibble(n, 1'b1);
  expect_record(r, 1'b0);
endtask

task automatic gen_load_c();
  dec_ins_t            r;
  logic [NIBBLE_W-1:0] n;
  logic [NIBBLE_W-1:0] d;
  r          = empty_record(gen_addr);
  n          = NIBBLE_W'(rand_below(16));
  r.alu_op   = ALU_OP_COPY;
  r.load_len = LEN_W'(n) + 1'b1;
  add_nibble(4'h3, 1'b0);
  add_nibble(n, 1'b0);
  // constant nibbles, lowest first
  for (int k = 0; k <= int'(n); k++) begin
    d = NIBBLE_W'(rand_below(16));
    r.load_value[k*NIBBLE_W +: NIBBLE_W] = d;
    add_nibble(d, k == int'(n));
  end
  expect_record(r, 1'b0);
endtask

task automatic gen_jump();
  dec_ins_t            r;
  logic [NIBBLE_W-1:0] op;
  logic [NIBBLE_W-1:0] d;
  int                  cnt;
  r   = empty_record(gen_addr);
  op  = NIBBLE_W'(4 + rand_below(4));
  cnt = (op < 4'h6) ? 2 : 3;
  r.load_len = LEN_W'(cnt);
  if (op < 4'h6) begin
    // GOC tests carry set, GONC carry clear
    r.alu_op     = ALU_OP_JMP_REL2;
    r.test_carry = 1'b1;
    r.carry_val  = (op == 4'h4);
  end else begin
    r.alu_op = ALU_OP_JMP_REL3;
    r.push   = (op == 4'h7);
  end
  add_nibble(op, 1'b0);
  for (int k = 0; k < cnt; k++) begin
    d = NIBBLE_W'(rand_below(16));
    r.load_value[k*NIBBLE_W +: NIBBLE_W] = d;
    add_nibble(d, k == cnt - 1);
  end
  expect_record(r, 1'b0);
endtask

task automatic gen_bad();
  dec_ins_t r;
  int       pick;
  r    = empty_record(gen_addr);
  pick = rand_below(10);
  if (pick == 9) begin
    add_nibble(4'h0, 1'b0);
    add_nibble(4'hE, 1'b1);
  end else begin
    // 1, or one of 8 to F
    add_nibble((pick == 0) ? 4'h1 : NIBBLE_W'(7 + pick), 1'b1);
  end
  expect_record(r, 1'b1);
endtask

task automatic gen_instr(input int mode);
  int pick;
  pick = mode;
  if (mode == MODE_ERRS) begin
    pick = (rand_below(2) == 0) ? MODE_ERRS : rand_below(4);
  end else if (mode == MODE_ANY) begin
    pick = rand_below(5);
  end
  case (pick)
    MODE_GRP0:  gen_group0();
    MODE_LOADP: gen_load_p();
    MODE_LOADC: gen_load_c();
    MODE_JUMP:  gen_jump();
    default:    gen_bad();
  endcase
endtask

// ==== tb_saturn_decoder.sv ====
/*
 * testbench for the saturn instruction decoder
 * random instruction streams, with and without stalls, checked
 * against a reference model, one result line per test
 */
`timescale 1ns/1ps
`default_nettype none

module tb_saturn_decoder
  import dec_pkg::*;
();

  localparam int RESET_CYCLES = 8;
  localparam int N_GRP0       = 40;
  localparam int N_LOADP      = 24;
  localparam int N_LOADC      = 30;
  localparam int N_JUMP       = 40;
  localparam int N_ERRS       = 40;
  localparam int N_MIXED      = 80;
  localparam int TOTAL_INSTR  = N_GRP0 + N_LOADP + N_LOADC + N_JUMP + N_ERRS + N_MIXED;
  localparam int TIMEOUT_CYCLES = TOTAL_INSTR * 24 + RESET_CYCLES;
  localparam logic [ADDR_W-1:0] PC_START = 20'h04a10;

  logic                i_clk     = 1'b0;
  logic                i_reset   = 1'b1;
  logic                i_en_dec  = 1'b0;
  logic                i_stalled = 1'b0;
  logic [ADDR_W-1:0]   i_pc      = PC_START;
  logic [NIBBLE_W-1:0] i_nibble  = '0;
  dec_ins_t            o_ins;
  logic                o_ins_decoded;
  logic                o_dec_error;

  // nibble stream still to be fed, and what the DUT owes us
  logic [NIBBLE_W-1:0] stim_nib[$];
  bit                  stim_last[$];
  dec_ins_t            exp_ins[$];
  bit                  exp_err[$];
  int                  due_q[$];

  logic [ADDR_W-1:0] gen_addr    = PC_START;
  logic [31:0]       lcg_state   = 32'ha5c9;
  int                edge_idx    = 0;
  int                run_cycles  = 0;
  bit                stall_on    = 1'b0;
  string             cur_test    = "reset";
  int                error_count = 0;
  int                check_count = 0;
  int                tests_run   = 0;
  int                tests_failed = 0;

  saturn_decoder DUT (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_en_dec      (i_en_dec),
    .i_stalled     (i_stalled),
    .i_pc          (i_pc),
    .i_nibble      (i_nibble),
    .o_ins         (o_ins),
    .o_ins_decoded (o_ins_decoded),
    .o_dec_error   (o_dec_error)
  );

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // upper half only, the low bits of the lcg cycle quickly
  function automatic int rand_below(input int n);
    return int'(next_rand() >> 16) % n;
  endfunction

  `include "tb_decoder_model.svh"

  task automatic compare_value(input string what, input logic [127:0] expected,
                               input logic [127:0] actual);
    check_count++;
    if (expected !== actual) begin
      error_count++;
      $display("Mismatch %s %s: expected %h, actual %h", cur_test, what, expected, actual);
    end
  endtask

  task automatic report_failure(input string msg);
    error_count++;
    $display("Error in %s: %s", cur_test, msg);
  endtask

  initial begin
    forever #10 i_clk = ~i_clk;
  end

  // feed the stream, one nibble per accepted edge
  always @(posedge i_clk) begin
    edge_idx = edge_idx + 1;
    if (i_en_dec && !i_stalled && stim_nib.size() > 0) begin
      i_pc <= i_pc + 1'b1;
      void'(stim_nib.pop_front());
      // pulse due two edges after the final nibble
      if (stim_last.pop_front()) begin
        due_q.push_back(edge_idx + 1);
      end
    end
    if (i_reset || stim_nib.size() == 0) begin
      i_en_dec  <= 1'b0;
      i_stalled <= 1'b0;
      i_nibble  <= NIBBLE_W'(rand_below(16));
    end else if (stall_on && rand_below(4) == 0) begin
      i_en_dec  <= 1'(rand_below(2));
      i_stalled <= 1'b1;
      i_nibble  <= NIBBLE_W'(rand_below(16));
    end else if (stall_on && rand_below(8) == 0) begin
      i_en_dec  <= 1'b0;
      i_stalled <= 1'(rand_below(2));
      i_nibble  <= NIBBLE_W'(rand_below(16));
    end else begin
      i_en_dec  <= 1'b1;
      i_stalled <= 1'b0;
      i_nibble  <= stim_nib[0];
    end
  end

  // outputs are stable at the falling edge
  always @(negedge i_clk) begin
    if (!i_reset) begin
      if (o_ins_decoded && o_dec_error) begin
        report_failure("decoded and error pulses are high in the same cycle");
      end
      if (o_ins_decoded || o_dec_error) begin
        if (exp_err.size() == 0 || due_q.size() == 0) begin
          report_failure("pulse arrived before any instruction was complete");
        end else begin
          compare_value("pulse cycle", 128'(due_q[0]), 128'(edge_idx));
          compare_value("error pulse", 128'(exp_err[0]), 128'(o_dec_error));
          if (!exp_err[0] && o_ins_decoded) begin
            compare_value("record", 128'(exp_ins[0]), 128'(o_ins));
          end
          void'(exp_ins.pop_front());
          void'(exp_err.pop_front());
          void'(due_q.pop_front());
        end
      end else if (due_q.size() > 0 && due_q[0] <= edge_idx) begin
        report_failure($sformatf("no pulse for the instruction at pc %h", exp_ins[0].ins_addr));
        void'(exp_ins.pop_front());
        void'(exp_err.pop_front());
        void'(due_q.pop_front());
      end
    end
  end

  always @(posedge i_clk) begin
    run_cycles = run_cycles + 1;
    if (run_cycles > TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles with %0d instructions outstanding",
               run_cycles, exp_err.size());
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic run_test(input string name, input int count, input int mode,
                          input bit stalls);
    int errors_before;
    errors_before = error_count;
    @(negedge i_clk);
    cur_test = name;
    stall_on = stalls;
    for (int i = 0; i < count; i++) begin
      gen_instr(mode);
    end
    @(posedge i_clk);
    while (exp_err.size() != 0) begin
      @(posedge i_clk);
    end
    // a few idle cycles catch stray pulses
    repeat (4) @(posedge i_clk);
    tests_run++;
    if (error_count != errors_before) begin
      tests_failed++;
    end
    $display("%s: %0d instructions, %0d errors, %s", name, count,
             error_count - errors_before, (error_count == errors_before) ? "pass" : "FAIL");
  endtask

  initial begin
    repeat (RESET_CYCLES) @(posedge i_clk);
    i_reset <= 1'b0;
    run_test("group0", N_GRP0, MODE_GRP0, 1'b0);
    run_test("load_p", N_LOADP, MODE_LOADP, 1'b0);
    run_test("load_c", N_LOADC, MODE_LOADC, 1'b0);
    run_test("jumps", N_JUMP, MODE_JUMP, 1'b0);
    run_test("errors", N_ERRS, MODE_ERRS, 1'b0);
    run_test("stalls", N_MIXED, MODE_ANY, 1'b1);
    $display("%0d tests, %0d failed, %0d instructions, %0d checks, %0d errors",
             tests_run, tests_failed, TOTAL_INSTR, check_count, error_count);
    if (error_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
